// File: Bender.yml
package:
  name: openadc_core

sources:
  - source/oadc_pkg.sv
  - source/oadc_regs.sv
  - source/oadc_timebase.sv
  - source/extclk_monitor.sv
  - source/adc_level_trigger.sv
  - source/oadc_readback.sv
  - source/openadc_core.sv
  - target: simulation
    files:
      - tb/tb_openadc_core.sv

// File: files.f
source/oadc_pkg.sv
source/oadc_regs.sv
source/oadc_timebase.sv
source/extclk_monitor.sv
source/adc_level_trigger.sv
source/oadc_readback.sv
source/openadc_core.sv
tb/tb_openadc_core.sv

// File: source/adc_level_trigger.sv
`default_nettype none

module adc_level_trigger (
   input  wire                     clk_usb,
   input  wire                     reset,
   input  wire oadc_pkg::adc_sample_t adc_data_i,
   input  wire                     source_adc_i,
   input  wire                     arm_i,
   input  wire oadc_pkg::adc_sample_t level_i,
   output oadc_pkg::trig_stat_t    trig_stat_o
);
   import oadc_pkg::*;

   adc_sample_t test_count;
   adc_sample_t stage1;
   adc_sample_t stage2;
   logic        arm_q;
   logic        allowed_q;
   logic        fired_q;
   logic        hit;

   // level msb set: fire above level, else below
   assign hit = allowed_q &
                (level_i[ADC_W-1] ? (stage2 > level_i) : (stage2 < level_i));

   // sample path, two stages
   always_ff @(posedge clk_usb) begin
      stage1 <= source_adc_i ? adc_data_i : test_count;
      stage2 <= stage1;
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         test_count <= '0;
         arm_q      <= 1'b0;
         allowed_q  <= 1'b0;
         fired_q    <= 1'b0;
      end else begin
         test_count <= test_count + 1'b1;
         arm_q      <= arm_i;
         fired_q    <= hit;
         // clear on the same edge as the pulse, so one shot per arm
         if (hit)
            allowed_q <= 1'b0;
         else if (arm_i && !arm_q)
            allowed_q <= 1'b1;
      end
   end

   assign trig_stat_o.armed   = arm_i;
   assign trig_stat_o.allowed = allowed_q;
   assign trig_stat_o.fired   = fired_q;

endmodule

`default_nettype wire

// File: source/extclk_monitor.sv
`default_nettype none

module extclk_monitor (
   input  wire                              clk_usb,
   input  wire                              reset,
   input  wire                              dut_clk_i,
   input  wire                              gate_i,
   input  wire [oadc_pkg::REG_DATA_W-1:0]   limit_i,
   input  wire                              monitor_disable_i,
   output oadc_pkg::extclk_stat_t           ext_stat_o
);
   import oadc_pkg::*;

   logic  sync_meta;
   logic  sync_q;
   logic  sync_prev;
   logic  edge_seen;
   freq_t count;
   freq_t freq_q;
   freq_t diff;
   logic  change_q;

   // target clock is only data here
   assign edge_seen = sync_q & ~sync_prev;

   assign diff = (freq_q > count) ? freq_q - count : count - freq_q;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         sync_meta <= 1'b0;
         sync_q    <= 1'b0;
         sync_prev <= 1'b0;
         count     <= '0;
         freq_q    <= '0;
         change_q  <= 1'b0;
      end else begin
         sync_meta <= dut_clk_i;
         sync_q    <= sync_meta;
         sync_prev <= sync_q;

         if (gate_i) begin
            freq_q <= count;
            count  <= freq_t'(edge_seen); // an edge here opens the new window
         end else begin
            count <= count + freq_t'(edge_seen);
         end

         // sticky until software sets monitor_disable
         if (monitor_disable_i)
            change_q <= 1'b0;
         else if (gate_i && (freq_q != '0) && (diff > freq_t'(limit_i)))
            change_q <= 1'b1;
      end
   end

   assign ext_stat_o.frequency = freq_q;
   assign ext_stat_o.change    = change_q;

endmodule

`default_nettype wire

// File: source/oadc_pkg.sv
`default_nettype none

package oadc_pkg;

   localparam int REG_ADDR_W = 8;
   localparam int REG_DATA_W = 8;
   localparam int ADC_W = 12;
   localparam int FREQ_W = 24;
   localparam int GATE_LOG2_DEFAULT = 23;

   // register map
   localparam logic [REG_ADDR_W-1:0] ADDR_SETTINGS = 8'd0;
   localparam logic [REG_ADDR_W-1:0] ADDR_GAIN = 8'd1;
   localparam logic [REG_ADDR_W-1:0] ADDR_TRIG_LEVEL_LO = 8'd2;
   localparam logic [REG_ADDR_W-1:0] ADDR_TRIG_LEVEL_HI = 8'd3; // low nibble only
   localparam logic [REG_ADDR_W-1:0] ADDR_EXTCLK_LIMIT = 8'd4;
   localparam logic [REG_ADDR_W-1:0] ADDR_STATUS = 8'd5;
   localparam logic [REG_ADDR_W-1:0] ADDR_EXTCLK_FREQ0 = 8'd6;
   localparam logic [REG_ADDR_W-1:0] ADDR_EXTCLK_FREQ1 = 8'd7;
   localparam logic [REG_ADDR_W-1:0] ADDR_EXTCLK_FREQ2 = 8'd8;

   // bit positions in the settings byte
   localparam int SET_ARM = 0;
   localparam int SET_LED_LSB = 1;
   localparam int SET_SOURCE = 3;
   localparam int SET_MON_DIS = 4;

   localparam logic [1:0] LED_SEL_STATE = 2'd0;
   localparam logic [1:0] LED_SEL_HEARTBEAT = 2'd1;
   localparam logic [1:0] LED_SEL_MONITOR = 2'd2;
   localparam logic [1:0] LED_SEL_GAIN = 2'd3;

   typedef logic [ADC_W-1:0] adc_sample_t;
   typedef logic [FREQ_W-1:0] freq_t;

   typedef struct packed {
      logic                  arm;
      logic [1:0]            led_select;
      logic                  data_source_select; // 1 = adc, 0 = test counter
      logic                  monitor_disable;
      logic [REG_DATA_W-1:0] gain;
      adc_sample_t           trig_level;         // top bit picks the direction
      logic [REG_DATA_W-1:0] extclk_limit;
   } oadc_cfg_t;

   typedef struct packed {
      logic gate;
      logic flash;
      logic heartbeat;
      logic amp_gain;
   } timebase_t;

   typedef struct packed {
      freq_t frequency;
      logic  change;
   } extclk_stat_t;

   typedef struct packed {
      logic armed;
      logic allowed;
      logic fired;
   } trig_stat_t;

endpackage

`default_nettype wire

// File: source/oadc_readback.sv
`default_nettype none

module oadc_readback (
   input  wire [oadc_pkg::REG_ADDR_W-1:0]   reg_address_i,
   input  wire                              reg_read_i,
   input  wire oadc_pkg::oadc_cfg_t         cfg_i,
   input  wire oadc_pkg::timebase_t         tb_stat_i,
   input  wire oadc_pkg::extclk_stat_t      ext_stat_i,
   input  wire oadc_pkg::trig_stat_t        trig_stat_i,
   input  wire                              pll_status_i,
   input  wire                              dut_trigger_i,
   output logic [oadc_pkg::REG_DATA_W-1:0]  reg_datao_o,
   output logic                             led_armed_o,
   output logic                             led_capture_o
);
   import oadc_pkg::*;

   logic [REG_DATA_W-1:0] status;
   logic [REG_DATA_W-1:0] settings;
   logic [REG_DATA_W-1:0] rd_mux;

   always_comb begin
      settings = '0;
      settings[SET_ARM] = cfg_i.arm;
      settings[SET_LED_LSB +: 2] = cfg_i.led_select;
      settings[SET_SOURCE] = cfg_i.data_source_select;
      settings[SET_MON_DIS] = cfg_i.monitor_disable;
   end

   assign status = {tb_stat_i.flash, 1'b0, ext_stat_i.change, pll_status_i,
                    1'b0, dut_trigger_i, ~trig_stat_i.allowed, trig_stat_i.armed};

   always_comb begin
      case (reg_address_i)
         ADDR_SETTINGS:      rd_mux = settings;
         ADDR_GAIN:          rd_mux = cfg_i.gain;
         ADDR_TRIG_LEVEL_LO: rd_mux = cfg_i.trig_level[7:0];
         ADDR_TRIG_LEVEL_HI: rd_mux = {4'b0, cfg_i.trig_level[ADC_W-1:8]};
         ADDR_EXTCLK_LIMIT:  rd_mux = cfg_i.extclk_limit;
         ADDR_STATUS:        rd_mux = status;
         ADDR_EXTCLK_FREQ0:  rd_mux = ext_stat_i.frequency[7:0];
         ADDR_EXTCLK_FREQ1:  rd_mux = ext_stat_i.frequency[15:8];
         ADDR_EXTCLK_FREQ2:  rd_mux = ext_stat_i.frequency[23:16];
         default:            rd_mux = '0;
      endcase
   end

   assign reg_datao_o = reg_read_i ? rd_mux : '0;

   // a clock change overrides the led selection
   always_comb begin
      if (ext_stat_i.change) begin
         led_armed_o   = tb_stat_i.flash;
         led_capture_o = tb_stat_i.flash;
      end else begin
         case (cfg_i.led_select)
            LED_SEL_STATE: begin
               led_armed_o   = trig_stat_i.armed;
               led_capture_o = trig_stat_i.allowed;
            end
            LED_SEL_HEARTBEAT: begin
               led_armed_o   = tb_stat_i.heartbeat;
               led_capture_o = ~tb_stat_i.heartbeat;
            end
            LED_SEL_MONITOR: begin
               led_armed_o   = tb_stat_i.heartbeat;
               led_capture_o = ext_stat_i.change;
            end
            default: begin // gain pwm
               led_armed_o   = tb_stat_i.amp_gain;
               led_capture_o = tb_stat_i.amp_gain;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/oadc_regs.sv
`default_nettype none

module oadc_regs (
   input  wire                              clk_usb,
   input  wire                              reset,
   input  wire [oadc_pkg::REG_ADDR_W-1:0]   reg_address_i,
   input  wire [oadc_pkg::REG_DATA_W-1:0]   reg_datai_i,
   input  wire                              reg_write_i,
   output oadc_pkg::oadc_cfg_t              cfg_o
);
   import oadc_pkg::*;

   oadc_cfg_t cfg_q;

   // config lands at the write edge, visible from the next cycle
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         cfg_q <= '0;
      end else if (reg_write_i) begin
         case (reg_address_i)
            ADDR_SETTINGS: begin
               cfg_q.arm                <= reg_datai_i[SET_ARM];
               cfg_q.led_select         <= reg_datai_i[SET_LED_LSB +: 2];
               cfg_q.data_source_select <= reg_datai_i[SET_SOURCE];
               cfg_q.monitor_disable    <= reg_datai_i[SET_MON_DIS];
            end
            ADDR_GAIN: begin
               cfg_q.gain <= reg_datai_i;
            end
            ADDR_TRIG_LEVEL_LO: begin
               cfg_q.trig_level[7:0] <= reg_datai_i;
            end
            ADDR_TRIG_LEVEL_HI: begin
               cfg_q.trig_level[ADC_W-1:8] <= reg_datai_i[ADC_W-9:0]; // upper nibble dropped
            end
            ADDR_EXTCLK_LIMIT: begin
               cfg_q.extclk_limit <= reg_datai_i;
            end
            default: begin
               cfg_q <= cfg_q; // read-only or unmapped
            end
         endcase
      end
   end

   assign cfg_o = cfg_q;

endmodule

`default_nettype wire

// File: source/oadc_timebase.sv
`default_nettype none

module oadc_timebase #(
   parameter int GATE_LOG2 = oadc_pkg::GATE_LOG2_DEFAULT
) (
   input  wire                              clk_usb,
   input  wire                              reset,
   input  wire [oadc_pkg::REG_DATA_W-1:0]   gain_i,
   output oadc_pkg::timebase_t              tb_stat_o
);
   import oadc_pkg::*;

   localparam int CNT_W = GATE_LOG2 + 4;

   logic [CNT_W-1:0]      count;
   logic                  gate_bit_q;
   logic                  gate_q;
   logic                  flash_q;
   logic [REG_DATA_W:0]   pwm_acc; // msb is the carry out

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         count      <= '0;
         gate_bit_q <= 1'b0;
         gate_q     <= 1'b0;
         flash_q    <= 1'b0;
         pwm_acc    <= '0;
      end else begin
         count      <= count + 1'b1;
         gate_bit_q <= count[GATE_LOG2];
         gate_q     <= count[GATE_LOG2] & ~gate_bit_q; // one cycle per rise
         if (count[GATE_LOG2+3])
            flash_q <= ~count[GATE_LOG2+1];
         // first-order sigma-delta, carry is high gain times per 256
         pwm_acc <= {1'b0, pwm_acc[REG_DATA_W-1:0]} + {1'b0, gain_i};
      end
   end

   assign tb_stat_o.gate      = gate_q;
   assign tb_stat_o.flash     = flash_q;
   assign tb_stat_o.heartbeat = count[GATE_LOG2+1];
   assign tb_stat_o.amp_gain  = pwm_acc[REG_DATA_W];

endmodule

`default_nettype wire

// File: source/openadc_core.sv
`default_nettype none

module openadc_core #(
   parameter int GATE_LOG2 = oadc_pkg::GATE_LOG2_DEFAULT
) (
   input  wire                              clk_usb,
   input  wire                              reset,

   input  wire [oadc_pkg::REG_ADDR_W-1:0]   reg_address_i,
   input  wire [oadc_pkg::REG_DATA_W-1:0]   reg_datai_i,
   input  wire                              reg_write_i,
   input  wire                              reg_read_i,
   output logic [oadc_pkg::REG_DATA_W-1:0]  reg_datao_o,

   input  wire oadc_pkg::adc_sample_t       adc_data_i,
   input  wire                              dut_clk_i,
   input  wire                              dut_trigger_i,
   input  wire                              pll_status_i,

   output logic                             trigger_adc_o,
   output logic                             freq_measure_o,
   output logic                             amp_gain_o,
   output logic                             flash_pattern_o,
   output logic                             led_armed_o,
   output logic                             led_capture_o
);
   import oadc_pkg::*;

   oadc_cfg_t    cfg;
   timebase_t    tb_stat;
   extclk_stat_t ext_stat;
   trig_stat_t   trig_stat;

   oadc_regs i_regs (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .reg_address_i (reg_address_i),
      .reg_datai_i   (reg_datai_i),
      .reg_write_i   (reg_write_i),
      .cfg_o         (cfg)
   );

   oadc_timebase #(
      .GATE_LOG2 (GATE_LOG2)
   ) i_timebase (
      .clk_usb   (clk_usb),
      .reset     (reset),
      .gain_i    (cfg.gain),
      .tb_stat_o (tb_stat)
   );

   extclk_monitor i_extclk_monitor (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .dut_clk_i         (dut_clk_i),
      .gate_i            (tb_stat.gate),
      .limit_i           (cfg.extclk_limit),
      .monitor_disable_i (cfg.monitor_disable),
      .ext_stat_o        (ext_stat)
   );

   adc_level_trigger i_level_trigger (
      .clk_usb      (clk_usb),
      .reset        (reset),
      .adc_data_i   (adc_data_i),
      .source_adc_i (cfg.data_source_select),
      .arm_i        (cfg.arm),
      .level_i      (cfg.trig_level),
      .trig_stat_o  (trig_stat)
   );

   oadc_readback i_readback (
      .reg_address_i (reg_address_i),
      .reg_read_i    (reg_read_i),
      .cfg_i         (cfg),
      .tb_stat_i     (tb_stat),
      .ext_stat_i    (ext_stat),
      .trig_stat_i   (trig_stat),
      .pll_status_i  (pll_status_i),
      .dut_trigger_i (dut_trigger_i),
      .reg_datao_o   (reg_datao_o),
      .led_armed_o   (led_armed_o),
      .led_capture_o (led_capture_o)
   );

   assign trigger_adc_o   = trig_stat.fired;
   assign freq_measure_o  = tb_stat.gate;
   assign amp_gain_o      = tb_stat.amp_gain;
   assign flash_pattern_o = tb_stat.flash;

endmodule

`default_nettype wire

// File: tb/openadc_trace.txt
# op and hex args: W addr data | R addr expect [mask] | P pll trig | Z | G gain | N name
# B quiet cross pulses | X | D period | F | E cycles | Y cycles
N reset_state
Z
N readback
W 0 1E
R 0 1E
W 1 5A
R 1 5A
W 2 34
R 2 34
W 3 A7
R 3 07
W 4 08
R 4 08
P 1 1
R 5 16 7F
P 0 0
R 5 02 7F
R 9 00
R FF 00
N pwm_gain
G 40
G C1
G 00
N trig_above
W 0 08
W 3 0A
W 0 09
B 14 5 1
N trig_no_rearm
B 8 4 0
N trig_below
W 0 08
W 3 03
W 0 09
B 10 3 1
N test_counter
W 3 09
X
N freq_monitor
W 0 00
D 4
F
W 0 10
W 0 00
D 10
F
R 5 20 20
E 80
W 0 10
R 5 00 20
Y 20

// File: tb/tb_openadc_core.sv
`default_nettype none

module tb_openadc_core;
   timeunit 1ns;
   timeprecision 100ps;
   import oadc_pkg::*;

   localparam int GATE_LOG2 = 6;
   localparam int GATE_PERIOD = 2 ** (GATE_LOG2 + 1); // cycles between gate pulses
   localparam int FLASH_SPAN = 2 ** (GATE_LOG2 + 4); // one full flash cycle
   localparam int SEED = 47878;

   typedef struct packed {
      logic [7:0]  op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [1:0]  nargs;
   } trace_cmd_t;

   logic                  clk_usb;
   logic                  reset;
   logic [REG_ADDR_W-1:0] reg_address_i;
   logic [REG_DATA_W-1:0] reg_datai_i;
   logic                  reg_write_i;
   logic                  reg_read_i;
   logic [REG_DATA_W-1:0] reg_datao_o;
   adc_sample_t           adc_data_i;
   logic                  dut_clk_i = 1'b0;
   logic                  dut_trigger_i;
   logic                  pll_status_i;
   logic                  trigger_adc_o;
   logic                  freq_measure_o;
   logic                  amp_gain_o;
   logic                  flash_pattern_o;
   logic                  led_armed_o;
   logic                  led_capture_o;

   trace_cmd_t cmds[$];
   string      names[$];
   string      test_name = "none";
   int         trig_cycles[$];   // cycle of every trigger pulse
   int         cyc = 0;
   int         rst_cyc = 0;
   int         cycle_limit = 0;
   logic       limit_ready = 1'b0;
   int         gate_count = 0;
   int         dut_half = 0;
   int         dut_phase = 0;
   int         dut_period = 0;
   int         level_sh = 0;     // shadow of the trigger level
   int         checks = 0;
   int         mismatches = 0;
   int         other_errors = 0;

   openadc_core #(
      .GATE_LOG2 (GATE_LOG2)
   ) i_dut (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .reg_address_i   (reg_address_i),
      .reg_datai_i     (reg_datai_i),
      .reg_write_i     (reg_write_i),
      .reg_read_i      (reg_read_i),
      .reg_datao_o     (reg_datao_o),
      .adc_data_i      (adc_data_i),
      .dut_clk_i       (dut_clk_i),
      .dut_trigger_i   (dut_trigger_i),
      .pll_status_i    (pll_status_i),
      .trigger_adc_o   (trigger_adc_o),
      .freq_measure_o  (freq_measure_o),
      .amp_gain_o      (amp_gain_o),
      .flash_pattern_o (flash_pattern_o),
      .led_armed_o     (led_armed_o),
      .led_capture_o   (led_capture_o)
   );

   initial begin
      clk_usb = 1'b0;
      forever #4 clk_usb = ~clk_usb;
   end

   always @(posedge clk_usb) cyc <= cyc + 1;

   always @(negedge clk_usb) begin
      if (trigger_adc_o)
         trig_cycles.push_back(cyc);
      if (freq_measure_o)
         gate_count++;
   end

   // target clock, period 2*dut_half cycles
   always @(posedge clk_usb) begin
      #1;
      if (dut_half == 0) begin
         dut_clk_i = 1'b0;
         dut_phase = 0;
      end else if (dut_phase >= dut_half - 1) begin
         dut_phase = 0;
         dut_clk_i = ~dut_clk_i;
      end else begin
         dut_phase++;
      end
   end

   task automatic log_wrong_value(input string what, input int expected, input int actual);
      $display("MISMATCH %s %s: expected 0x%0h, actual 0x%0h", test_name, what,
               expected, actual);
      mismatches++;
   endtask

   task automatic log_failure(input string msg);
      $display("ERROR %s: %s", test_name, msg);
      other_errors++;
   endtask

   function automatic string strip_eol(input string s);
      string t;
      t = s;
      while (t.len() > 0 && (t.getc(t.len() - 1) == "\n" || t.getc(t.len() - 1) == "\r"))
         t = t.substr(0, t.len() - 2);
      return t;
   endfunction

   task automatic load_trace();
      int         fd;
      int         cnt;
      int         a;
      int         b;
      int         c;
      string      line;
      trace_cmd_t cmd;
      fd = $fopen("tb/openadc_trace.txt", "r");
      if (fd == 0) begin
         log_failure("cannot open tb/openadc_trace.txt");
         return;
      end
      while ($fgets(line, fd) > 0) begin
         line = strip_eol(line);
         if (line.len() == 0 || line.getc(0) == "#")
            continue;
         cmd = '0;
         cmd.op = line.getc(0);
         if (cmd.op == "N") begin
            cmd.a = names.size();
            names.push_back(line.substr(2, line.len() - 1));
         end else if (line.len() > 1) begin
            a = 0;
            b = 0;
            c = 0;
            cnt = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
            cmd.nargs = (cnt > 0) ? cnt[1:0] : 2'd0;
            cmd.a = a;
            cmd.b = b;
            cmd.c = c;
         end
         cmds.push_back(cmd);
      end
      $fclose(fd);
      if (cmds.size() == 0)
         log_failure("trace holds no commands");
   endtask

   // rough cycle cost of one trace line
   function automatic int cmd_cycles(input trace_cmd_t c);
      case (c.op)
         "W", "R": return 2;
         "Z":      return 20;
         "G":      return 260;
         "B":      return c.a + c.b + 10;
         "X":      return 2 * 4096 + 40;
         "F":      return 3 * GATE_PERIOD + 10;
         "E":      return (c.a > FLASH_SPAN) ? c.a : FLASH_SPAN;
         "Y":      return c.a;
         default:  return 1;
      endcase
   endfunction

   // flash from the counter value before the last edge
   function automatic logic flash_expected();
      int m;
      m = cyc - rst_cyc - 1;
      return m[GATE_LOG2+3] & ~m[GATE_LOG2+1];
   endfunction

   function automatic adc_sample_t idle_sample();
      return level_sh[ADC_W-1] ? '0 : '1; // never crosses the level
   endfunction

   function automatic adc_sample_t pick_sample(input logic crossing);
      logic up;
      int   lo;
      int   hi;
      up = level_sh[ADC_W-1];
      if (up == crossing) begin
         lo = up ? level_sh + 1 : level_sh;
         hi = 4095;
      end else begin
         lo = 0;
         hi = up ? level_sh : level_sh - 1;
      end
      return adc_sample_t'(lo + ($urandom % (hi - lo + 1)));
   endfunction

   task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
      @(posedge clk_usb);
      #1;
      reg_address_i = addr;
      reg_datai_i = data;
      reg_write_i = 1'b1;
      if (addr == ADDR_TRIG_LEVEL_LO)
         level_sh = (level_sh & 'hF00) | int'(data);
      else if (addr == ADDR_TRIG_LEVEL_HI)
         level_sh = (level_sh & 'h0FF) | (int'(data[3:0]) << 8);
      adc_data_i = idle_sample();
      @(posedge clk_usb);
      #1;
      reg_write_i = 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
      @(posedge clk_usb);
      #1;
      reg_address_i = addr;
      reg_read_i = 1'b1;
      @(negedge clk_usb);
      data = reg_datao_o;
      @(posedge clk_usb);
      #1;
      reg_read_i = 1'b0;
   endtask

   task automatic read_check(input logic [7:0] addr, input logic [7:0] expected,
                             input logic [7:0] mask);
      logic [7:0] got;
      read_reg(addr, got);
      checks++;
      if ((got & mask) !== (expected & mask))
         log_wrong_value($sformatf("reg 0x%0h", addr), expected & mask, got & mask);
   endtask

   task automatic check_reset_state();
      logic [4:0] outs;
      @(negedge clk_usb);
      outs = {trigger_adc_o, amp_gain_o, freq_measure_o, led_armed_o, led_capture_o};
      checks++;
      if (outs !== 5'b0)
         log_wrong_value("outputs after reset", 0, outs);
      for (int a = 0; a <= ADDR_EXTCLK_FREQ2; a++) begin
         if (a == ADDR_STATUS)
            read_check(a[7:0], 8'h02, 8'h7F); // only not-allowed is high
         else
            read_check(a[7:0], 8'h00, 8'hFF);
      end
   endtask

   task automatic measure_pwm(input int gain);
      int highs;
      highs = 0;
      write_reg(ADDR_GAIN, gain[7:0]);
      repeat (2) @(posedge clk_usb);
      repeat (256) begin
         @(negedge clk_usb);
         if (amp_gain_o)
            highs++;
      end
      checks++;
      if (highs != gain)
         log_wrong_value("pwm high count", gain, highs);
   endtask

   task automatic adc_burst(input int n_quiet, input int n_cross, input int n_expect);
      int n0;
      int got;
      int cross_cyc;
      n0 = trig_cycles.size();
      cross_cyc = 0;
      for (int i = 0; i < n_quiet + n_cross; i++) begin
         @(posedge clk_usb);
         #1;
         adc_data_i = pick_sample(i >= n_quiet);
         if (i == n_quiet)
            cross_cyc = cyc;
      end
      @(posedge clk_usb);
      #1;
      adc_data_i = idle_sample();
      repeat (6) @(posedge clk_usb);
      @(negedge clk_usb);
      got = trig_cycles.size() - n0;
      checks++;
      if (got != n_expect)
         log_wrong_value("trigger count", n_expect, got);
      if (n_expect > 0 && got > 0) begin
         checks++;
         if (trig_cycles[n0] != cross_cyc + 3)
            log_wrong_value("trigger cycle", cross_cyc + 3, trig_cycles[n0]);
      end
   endtask

   // counter value follows from cycles since reset release
   task automatic test_counter_trigger();
      int n0;
      int seen;
      write_reg(ADDR_SETTINGS, 8'h00);
      @(negedge clk_usb);
      while (((cyc - rst_cyc) % 4096) > level_sh - 32)
         @(negedge clk_usb);
      n0 = trig_cycles.size();
      write_reg(ADDR_SETTINGS, 8'h01);
      wait (trig_cycles.size() > n0);
      seen = (trig_cycles[n0] - 3 - rst_cyc) % 4096;
      checks++;
      if (seen != level_sh + 1)
         log_wrong_value("counter at trigger", level_sh + 1, seen);
   endtask

   task automatic check_frequency();
      int         g0;
      int         expected;
      int         measured;
      logic [7:0] b0;
      logic [7:0] b1;
      logic [7:0] b2;
      g0 = gate_count;
      wait (gate_count >= g0 + 2); // second window is all new divider
      read_reg(ADDR_EXTCLK_FREQ0, b0);
      read_reg(ADDR_EXTCLK_FREQ1, b1);
      read_reg(ADDR_EXTCLK_FREQ2, b2);
      measured = {b2, b1, b0};
      expected = (dut_period == 0) ? 0 : GATE_PERIOD / dut_period;
      checks++;
      if (measured > expected + 1 || measured + 1 < expected)
         log_wrong_value("frequency", expected, measured);
   endtask

   task automatic check_led_flash(input int n);
      int   bad;
      int   flash_bad;
      int   span;
      logic exp_flash;
      bad = 0;
      flash_bad = 0;
      span = (n > FLASH_SPAN) ? n : FLASH_SPAN; // flash is high somewhere in it
      repeat (span) begin
         @(negedge clk_usb);
         exp_flash = flash_expected();
         if (flash_pattern_o !== exp_flash)
            flash_bad++;
         if (led_armed_o !== exp_flash || led_capture_o !== exp_flash)
            bad++;
      end
      checks += 2;
      if (flash_bad != 0)
         log_wrong_value("cycles with flash off its pattern", 0, flash_bad);
      if (bad != 0)
         log_wrong_value("cycles with leds off flash", 0, bad);
   endtask

   task automatic run_cmd(input trace_cmd_t c);
      case (c.op)
         "N": test_name = names[c.a];
         "W": write_reg(c.a[7:0], c.b[7:0]);
         "R": read_check(c.a[7:0], c.b[7:0], (c.nargs == 3) ? c.c[7:0] : 8'hFF);
         "P": begin
            @(posedge clk_usb);
            #1;
            pll_status_i = c.a[0];
            dut_trigger_i = c.b[0];
         end
         "Z": check_reset_state();
         "G": measure_pwm(c.a);
         "B": adc_burst(c.a, c.b, c.c);
         "X": test_counter_trigger();
         "D": begin
            dut_period = c.a;
            dut_half = c.a / 2;
         end
         "F": check_frequency();
         "E": check_led_flash(c.a);
         "Y": repeat (c.a) @(posedge clk_usb);
         default: log_failure($sformatf("unknown trace op %s", c.op));
      endcase
   endtask

   initial begin
      wait (limit_ready);
      while (cyc < cycle_limit)
         @(posedge clk_usb);
      $display("ERROR the run timed out after %0d cycles, %0d mismatches before that",
               cyc, mismatches);
      $display("TB FAILED");
      $finish;
   end

   initial begin
      reset = 1'b1;
      reg_address_i = '0;
      reg_datai_i = '0;
      reg_write_i = 1'b0;
      reg_read_i = 1'b0;
      adc_data_i = '0;
      dut_trigger_i = 1'b0;
      pll_status_i = 1'b0;
      void'($urandom(SEED));
      load_trace();
      cycle_limit = 2000;
      foreach (cmds[i])
         cycle_limit += cmd_cycles(cmds[i]);
      limit_ready = 1'b1;
      repeat (10) @(posedge clk_usb);
      #1;
      reset = 1'b0;
      rst_cyc = cyc;
      foreach (cmds[i])
         run_cmd(cmds[i]);
      repeat (4) @(posedge clk_usb);
      $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches,
               other_errors);
      if (mismatches == 0 && other_errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire
